/* bilinear_simd4.f */
rtl/bilinear_pkg.sv
rtl/bilinear_ctrl.sv
rtl/bilinear_coord.sv
rtl/bilinear_fetch.sv
rtl/bilinear_blend.sv
rtl/bilinear_simd4.sv
verif/bilinear_props.sv
verif/bilinear_checker.sv
verif/tb_bilinear_simd4.sv

/* rtl/bilinear_blend.sv */
`timescale 1ns/1ps

module bilinear_blend #(
  parameter int AW = 19
) (
  input  logic                                                                  clk,
  input  logic                                                                  rst_n,
  input  logic                                                                  i_mul,
  input  logic                                                                  i_write,
  input  bilinear_pkg::frac_t [bilinear_pkg::LANES-1:0]                         i_fx,
  input  bilinear_pkg::frac_t                                                   i_fy,
  input  bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0][bilinear_pkg::NBR-1:0] i_samples,
  input  logic [bilinear_pkg::LANES-1:0]                                        i_lane_mask,
  input  logic [bilinear_pkg::LANES-1:0][AW-1:0]                                i_waddr,
  output logic [bilinear_pkg::LANES-1:0][AW-1:0]                                o_out_waddr,
  output bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0]                        o_out_wdata,
  output logic [bilinear_pkg::LANES-1:0]                                        o_out_we
);
  import bilinear_pkg::*;

  weight_t [LANES-1:0]          wx0;
  weight_t [LANES-1:0]          wx1;
  weight_t                      wy0;
  weight_t                      wy1;
  wprod_t  [LANES-1:0][NBR-1:0] wgt;
  acc_t    [LANES-1:0][NBR-1:0] prod;
  acc_t    [LANES-1:0]          sum;
  pixel_t  [LANES-1:0]          pix;

  assign wy0 = ONE_Q08 - weight_t'(i_fy);
  assign wy1 = weight_t'(i_fy);

  // --------------------
  // Weights and rounding
  // --------------------
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      wx0[l]    = ONE_Q08 - weight_t'(i_fx[l]);
      wx1[l]    = weight_t'(i_fx[l]);
      wgt[l][0] = wx0[l] * wy0;
      wgt[l][1] = wx1[l] * wy0;
      wgt[l][2] = wx0[l] * wy1;
      wgt[l][3] = wx1[l] * wy1;
      sum[l]    = prod[l][0] + prod[l][1] + prod[l][2] + prod[l][3] + ROUND_Q016;
      pix[l]    = sum[l][23:16];
    end
  end

  // Four Q8.16 products per lane
  always_ff @(posedge clk) begin
    if (i_mul) begin
      for (int l = 0; l < LANES; l++) begin
        for (int n = 0; n < NBR; n++) begin
          prod[l][n] <= wgt[l][n] * i_samples[l][n];
        end
      end
    end
  end

  // --------------------
  // Write ports
  // --------------------
  always_ff @(posedge clk) begin
    if (i_write) begin
      o_out_waddr <= i_waddr;
      o_out_wdata <= pix;
    end
  end

  // Lanes beyond out_w stay quiet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_out_we <= '0;
    end else begin
      o_out_we <= i_write ? i_lane_mask : '0;
    end
  end

endmodule

/* rtl/bilinear_coord.sv */
`timescale 1ns/1ps

module bilinear_coord #(
  parameter int AW = 19
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  bilinear_pkg::dim_t                             i_in_w,
  input  bilinear_pkg::dim_t                             i_in_h,
  input  bilinear_pkg::scale_t                           i_scale_q88,
  input  logic                                           i_start,
  input  logic                                           i_init,
  input  logic                                           i_row_init,
  input  logic                                           i_setup,
  input  logic                                           i_advance,
  output bilinear_pkg::dim_t                             o_out_w,
  output bilinear_pkg::dim_t                             o_out_h,
  output bilinear_pkg::dim_t  [bilinear_pkg::LANES-1:0]  o_xi,
  output bilinear_pkg::dim_t                             o_yi,
  output bilinear_pkg::frac_t [bilinear_pkg::LANES-1:0]  o_fx,
  output bilinear_pkg::frac_t                            o_fy,
  output logic [bilinear_pkg::LANES-1:0]                 o_lane_mask,
  output logic [bilinear_pkg::LANES-1:0][AW-1:0]         o_waddr,
  output logic                                           o_last_group,
  output logic                                           o_last_row
);
  import bilinear_pkg::*;

  logic [31:0]           size_w_prod;
  logic [31:0]           size_h_prod;
  scale_t                inv_next;
  scale_t                inv_scale;
  pos_t                  inv_step;
  dim_t                  groups_per_row;
  dim_t                  oy;
  dim_t                  group_x;
  pos_t                  sx_group;
  pos_t                  sy_row;
  pos_t                  y_pos;
  pos_t [LANES-1:0]      lane_pos;
  dim_t [LANES-1:0]      lane_ox;

  // Integer at or past size-1 snaps to the last full cell
  function automatic pos_t clamp_pos(pos_t p, dim_t size);
    if (p[23:8] >= size - 16'd1) begin
      return {size - 16'd2, 8'hFF};
    end
    return p;
  endfunction

  assign size_w_prod = i_in_w * i_scale_q88;
  assign size_h_prod = i_in_h * i_scale_q88;
  assign inv_next    = (i_scale_q88 == '0) ? INV_ZERO_SCALE :
                       scale_t'(32'd65536 / 32'(i_scale_q88));
  assign inv_step    = pos_t'(inv_scale);

  // --------------------
  // Frame and position counters
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_out_w        <= '0;
      o_out_h        <= '0;
      inv_scale      <= '0;
      groups_per_row <= '0;
      oy             <= '0;
      group_x        <= '0;
      sx_group       <= '0;
      sy_row         <= '0;
      o_lane_mask    <= '0;
    end else begin
      if (i_start) begin
        o_out_w        <= size_w_prod[23:8];
        o_out_h        <= size_h_prod[23:8];
        inv_scale      <= inv_next;
        groups_per_row <= dim_t'((32'(size_w_prod[23:8]) + LANES - 1) / LANES);
      end
      if (i_init) begin
        oy     <= '0;
        sy_row <= '0;
      end
      if (i_row_init) begin
        group_x  <= '0;
        sx_group <= '0;
      end
      if (i_advance) begin
        if (o_last_group) begin
          oy     <= oy + 16'd1;
          sy_row <= sy_row + inv_step;
        end else begin
          group_x  <= group_x + 16'd1;
          sx_group <= sx_group + pos_t'(inv_step * LANES);
        end
      end
      if (i_setup) begin
        for (int l = 0; l < LANES; l++) begin
          o_lane_mask[l] <= (lane_ox[l] < o_out_w);
        end
      end
    end
  end

  // --------------------
  // Lane positions
  // --------------------
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_ox[l]  = dim_t'(group_x * LANES) + dim_t'(l);
      lane_pos[l] = clamp_pos(sx_group + pos_t'(inv_step * l), i_in_w);
    end
  end

  assign y_pos = clamp_pos(sy_row, i_in_h);

  // Per-group coordinates and write addresses
  always_ff @(posedge clk) begin
    if (i_setup) begin
      o_yi <= y_pos[23:8];
      o_fy <= y_pos[7:0];
      for (int l = 0; l < LANES; l++) begin
        o_xi[l]    <= lane_pos[l][23:8];
        o_fx[l]    <= lane_pos[l][7:0];
        o_waddr[l] <= AW'(lin_addr(lane_ox[l], oy, o_out_w));
      end
    end
  end

  assign o_last_group = (group_x + 16'd1) >= groups_per_row;
  assign o_last_row   = (oy + 16'd1) >= o_out_h;

endmodule

/* rtl/bilinear_ctrl.sv */
`timescale 1ns/1ps

module bilinear_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic i_start,
  input  logic i_last_group,
  input  logic i_last_row,
  output logic o_busy,
  output logic o_done,
  output logic o_init,
  output logic o_row_init,
  output logic o_setup,
  output logic o_read_addr,
  output logic o_read_data,
  output logic o_mul,
  output logic o_write,
  output logic o_advance
);
  import bilinear_pkg::*;

  scaler_state_t state;
  scaler_state_t state_n;

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_n;
    end
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_n = state;
    case (state)
      S_IDLE: begin
        if (i_start) begin
          state_n = S_INIT;
        end
      end
      S_INIT:        state_n = S_ROW_INIT;
      S_ROW_INIT:    state_n = S_PIXEL_SETUP;
      S_PIXEL_SETUP: state_n = S_READ_A;
      S_READ_A:      state_n = S_READ_D;
      S_READ_D:      state_n = S_MUL;
      S_MUL:         state_n = S_WRITE;
      S_WRITE: begin
        // Last group of the last row ends the frame
        if (i_last_group && i_last_row) begin
          state_n = S_DONE;
        end else begin
          state_n = S_ADVANCE;
        end
      end
      S_ADVANCE: begin
        // Coord still shows the group just written
        if (i_last_group) begin
          state_n = S_ROW_INIT;
        end else begin
          state_n = S_PIXEL_SETUP;
        end
      end
      S_DONE:  state_n = S_IDLE;
      default: state_n = S_IDLE;
    endcase
  end

  // --------------------
  // Status
  // --------------------
  // Busy rises with S_INIT; done and the falling edge of busy coincide
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= (state == S_DONE);
      if (state == S_IDLE && i_start) begin
        o_busy <= 1'b1;
      end else if (state == S_DONE) begin
        o_busy <= 1'b0;
      end
    end
  end

  // Stage strobes decoded from the state
  assign o_init      = (state == S_INIT);
  assign o_row_init  = (state == S_ROW_INIT);
  assign o_setup     = (state == S_PIXEL_SETUP);
  assign o_read_addr = (state == S_READ_A);
  assign o_read_data = (state == S_READ_D);
  assign o_mul       = (state == S_MUL);
  assign o_write     = (state == S_WRITE);
  assign o_advance   = (state == S_ADVANCE);

endmodule

/* rtl/bilinear_fetch.sv */
`timescale 1ns/1ps

module bilinear_fetch #(
  parameter int AW = 19
) (
  input  logic                                                                  clk,
  input  logic                                                                  i_read_addr,
  input  logic                                                                  i_read_data,
  input  bilinear_pkg::dim_t                                                    i_in_w,
  input  bilinear_pkg::dim_t [bilinear_pkg::LANES-1:0]                          i_xi,
  input  bilinear_pkg::dim_t                                                    i_yi,
  output logic [bilinear_pkg::LANES-1:0][bilinear_pkg::NBR-1:0][AW-1:0]         o_in_raddr,
  input  bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0][bilinear_pkg::NBR-1:0] i_in_rdata,
  output bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0][bilinear_pkg::NBR-1:0] o_samples
);
  import bilinear_pkg::*;

  logic [LANES-1:0][NBR-1:0][AW-1:0] raddr_next;
  dim_t                              nb_x;
  dim_t                              nb_y;

  // --------------------
  // Neighbour addresses
  // --------------------
  // Bit 0 of the neighbour index steps X, bit 1 steps Y
  always_comb begin
    nb_x = '0;
    nb_y = '0;
    for (int l = 0; l < LANES; l++) begin
      for (int n = 0; n < NBR; n++) begin
        nb_x             = i_xi[l] + dim_t'(n & 1);
        nb_y             = i_yi + dim_t'(n >> 1);
        raddr_next[l][n] = AW'(lin_addr(nb_x, nb_y, i_in_w));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_read_addr) begin
      o_in_raddr <= raddr_next;
    end
  end

  // --------------------
  // Sample capture
  // --------------------
  // Memory answers the registered addresses in the following cycle
  always_ff @(posedge clk) begin
    if (i_read_data) begin
      o_samples <= i_in_rdata;
    end
  end

endmodule

/* rtl/bilinear_pkg.sv */
package bilinear_pkg;

  // --------------------
  // Group geometry
  // --------------------
  // Pixels per group; the write mask and X stepping assume four
  localparam int LANES = 4;

  // Neighbours per lane, ordered I00, I10, I01, I11
  localparam int NBR = 4;

  // --------------------
  // Fixed-point types
  // --------------------
  typedef logic [15:0] dim_t;     // Width, height or integer coordinate
  typedef logic [15:0] scale_t;   // Q8.8 scale or inverse
  typedef logic [23:0] pos_t;     // Q16.8 source position
  typedef logic [7:0]  frac_t;    // Q0.8 fraction
  typedef logic [8:0]  weight_t;  // Q1.8 axis weight, 0..256
  typedef logic [17:0] wprod_t;   // Q0.16 combined weight
  typedef logic [31:0] acc_t;     // Q8.16 product or sum
  typedef logic [7:0]  pixel_t;

  localparam weight_t ONE_Q08        = 9'd256;
  localparam acc_t    ROUND_Q016     = 32'h0000_8000;
  localparam scale_t  INV_ZERO_SCALE = 16'hFFFF;

  // --------------------
  // Scaler FSM
  // --------------------
  typedef enum logic [3:0] {
    S_IDLE        = 4'd0,
    S_INIT        = 4'd1,
    S_ROW_INIT    = 4'd2,
    S_PIXEL_SETUP = 4'd3,
    S_READ_A      = 4'd4,
    S_READ_D      = 4'd5,
    S_MUL         = 4'd6,
    S_WRITE       = 4'd7,
    S_ADVANCE     = 4'd8,
    S_DONE        = 4'd9
  } scaler_state_t;

  // Row-major linear address, caller truncates to its address width
  function automatic logic [31:0] lin_addr(dim_t x, dim_t y, dim_t width);
    return (32'(y) * 32'(width)) + 32'(x);
  endfunction

endpackage

/* rtl/bilinear_simd4.sv */
`timescale 1ns/1ps

module bilinear_simd4 #(
  parameter int AW = 19
) (
  input  logic                                                                  clk,
  input  logic                                                                  rst_n,
  input  logic                                                                  i_start,
  output logic                                                                  o_busy,
  output logic                                                                  o_done,
  input  bilinear_pkg::dim_t                                                    i_in_w,
  input  bilinear_pkg::dim_t                                                    i_in_h,
  input  bilinear_pkg::scale_t                                                  i_scale_q88,
  output bilinear_pkg::dim_t                                                    o_out_w,
  output bilinear_pkg::dim_t                                                    o_out_h,
  output logic [bilinear_pkg::LANES-1:0][bilinear_pkg::NBR-1:0][AW-1:0]         o_in_raddr,
  input  bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0][bilinear_pkg::NBR-1:0] i_in_rdata,
  output logic [bilinear_pkg::LANES-1:0][AW-1:0]                                o_out_waddr,
  output bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0]                        o_out_wdata,
  output logic [bilinear_pkg::LANES-1:0]                                        o_out_we
);
  import bilinear_pkg::*;

  // --------------------
  // Stage strobes
  // --------------------
  logic init;
  logic row_init;
  logic setup;
  logic read_addr;
  logic read_data;
  logic mul;
  logic write;
  logic advance;
  logic last_group;
  logic last_row;

  // --------------------
  // Datapath
  // --------------------
  dim_t   [LANES-1:0]          xi;
  dim_t                        yi;
  frac_t  [LANES-1:0]          fx;
  frac_t                       fy;
  logic   [LANES-1:0]          lane_mask;
  logic   [LANES-1:0][AW-1:0]  waddr;
  pixel_t [LANES-1:0][NBR-1:0] samples;

  bilinear_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_start      (i_start),
    .i_last_group (last_group),
    .i_last_row   (last_row),
    .o_busy       (o_busy),
    .o_done       (o_done),
    .o_init       (init),
    .o_row_init   (row_init),
    .o_setup      (setup),
    .o_read_addr  (read_addr),
    .o_read_data  (read_data),
    .o_mul        (mul),
    .o_write      (write),
    .o_advance    (advance)
  );

  bilinear_coord #(
    .AW (AW)
  ) u_coord (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_in_w       (i_in_w),
    .i_in_h       (i_in_h),
    .i_scale_q88  (i_scale_q88),
    .i_start      (i_start),
    .i_init       (init),
    .i_row_init   (row_init),
    .i_setup      (setup),
    .i_advance    (advance),
    .o_out_w      (o_out_w),
    .o_out_h      (o_out_h),
    .o_xi         (xi),
    .o_yi         (yi),
    .o_fx         (fx),
    .o_fy         (fy),
    .o_lane_mask  (lane_mask),
    .o_waddr      (waddr),
    .o_last_group (last_group),
    .o_last_row   (last_row)
  );

  bilinear_fetch #(
    .AW (AW)
  ) u_fetch (
    .clk         (clk),
    .i_read_addr (read_addr),
    .i_read_data (read_data),
    .i_in_w      (i_in_w),
    .i_xi        (xi),
    .i_yi        (yi),
    .o_in_raddr  (o_in_raddr),
    .i_in_rdata  (i_in_rdata),
    .o_samples   (samples)
  );

  bilinear_blend #(
    .AW (AW)
  ) u_blend (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_mul       (mul),
    .i_write     (write),
    .i_fx        (fx),
    .i_fy        (fy),
    .i_samples   (samples),
    .i_lane_mask (lane_mask),
    .i_waddr     (waddr),
    .o_out_waddr (o_out_waddr),
    .o_out_wdata (o_out_wdata),
    .o_out_we    (o_out_we)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the bilinear scaler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f bilinear_simd4.f \
  --top-module tb_bilinear_simd4 \
  -o sim_bilinear

./obj_dir/sim_bilinear +verilator+error+limit+100 | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* verif/bilinear_checker.sv */
`timescale 1ns/1ps

module bilinear_checker #(
  parameter int AW = 19
) (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           i_start,
  input  bilinear_pkg::dim_t                             i_in_w,
  input  bilinear_pkg::dim_t                             i_in_h,
  input  bilinear_pkg::scale_t                           i_scale_q88,
  input  logic                                           i_busy,
  input  logic                                           i_done,
  input  bilinear_pkg::dim_t                             i_out_w,
  input  bilinear_pkg::dim_t                             i_out_h,
  input  logic [bilinear_pkg::LANES-1:0][AW-1:0]         i_waddr,
  input  bilinear_pkg::pixel_t [bilinear_pkg::LANES-1:0] i_wdata,
  input  logic [bilinear_pkg::LANES-1:0]                 i_we,
  input  bilinear_pkg::pixel_t                           i_mem [0:255],
  output int                                             o_frames,
  output int                                             o_checks,
  output int                                             o_errors
);
  import bilinear_pkg::*;

  localparam int MAX_OUT = 4096;

  int     src_w;
  int     src_h;
  int     src_scale;
  int     inv;
  int     exp_w;
  int     exp_h;
  int     frame_writes;
  int     frame_errors;
  logic   active;
  pixel_t exp_pix [0:MAX_OUT-1];
  int     hits    [0:MAX_OUT-1];

  task automatic count_error();
    o_errors++;
    frame_errors++;
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Q16.8 position to integer and fraction, snapped at the far edge
  function automatic void split_pos(input int pos, input int size, output int ip, output int fp);
    ip = (pos >> 8) & 32'hFFFF;
    fp = pos & 32'hFF;
    if (ip >= size - 1) begin
      ip = size - 2;
      fp = 255;
    end
  endfunction

  function automatic int model_pixel(int ox, int oy);
    int xi;
    int fx;
    int yi;
    int fy;
    int sum;
    split_pos((ox * inv) & 32'hFF_FFFF, src_w, xi, fx);
    split_pos((oy * inv) & 32'hFF_FFFF, src_h, yi, fy);
    sum = (256 - fx) * (256 - fy) * int'(i_mem[yi * src_w + xi])
        + fx * (256 - fy) * int'(i_mem[yi * src_w + xi + 1])
        + (256 - fx) * fy * int'(i_mem[(yi + 1) * src_w + xi])
        + fx * fy * int'(i_mem[(yi + 1) * src_w + xi + 1])
        + 32'h8000;
    return (sum >> 16) & 32'hFF;
  endfunction

  task automatic load_frame();
    src_w     = int'(i_in_w);
    src_h     = int'(i_in_h);
    src_scale = int'(i_scale_q88);
    exp_w     = ((src_w * src_scale) >> 8) & 32'hFFFF;
    exp_h     = ((src_h * src_scale) >> 8) & 32'hFFFF;
    if (src_scale == 0) begin
      inv = 32'hFFFF;
    end else begin
      inv = 65536 / src_scale;
    end
    frame_writes = 0;
    frame_errors = 0;
    for (int a = 0; a < MAX_OUT; a++) begin
      hits[a] = 0;
    end
    for (int oy = 0; oy < exp_h; oy++) begin
      for (int ox = 0; ox < exp_w; ox++) begin
        exp_pix[oy * exp_w + ox] = pixel_t'(model_pixel(ox, oy));
      end
    end
    active = 1'b1;
  endtask

  // --------------------
  // Write and frame checks
  // --------------------
  task automatic check_write(input int lane);
    int addr;
    int ox;
    int oy;
    addr = int'(i_waddr[lane]);
    o_checks++;
    frame_writes++;
    if (!active) begin
      $display("Error at %0t: lane %0d raised its write enable outside a frame", $time, lane);
      count_error();
      return;
    end
    if (addr >= exp_w * exp_h) begin
      $display("Error at %0t: lane %0d wrote address %0d beyond the %0dx%0d output",
               $time, lane, addr, exp_w, exp_h);
      count_error();
      return;
    end
    ox = addr % exp_w;
    oy = addr / exp_w;
    // Lane l owns columns l, l+4, l+8 and so on
    if (ox % LANES != lane) begin
      $display("Error at %0t: lane %0d wrote column %0d of another lane", $time, lane, ox);
      count_error();
    end
    hits[addr]++;
    if (hits[addr] > 1) begin
      $display("Error at %0t: address %0d written %0d times", $time, addr, hits[addr]);
      count_error();
    end
    if (i_wdata[lane] !== exp_pix[addr]) begin
      $display("Mismatch at %0t: o_out_wdata[%0d] addr %0d actual 0x%02h expected 0x%02h",
               $time, lane, addr, i_wdata[lane], exp_pix[addr]);
      count_error();
    end
    // Unit scale copies the input wherever no clamp applies
    if (src_scale == 32'h100 && ox < src_w - 1 && oy < src_h - 1) begin
      if (i_wdata[lane] !== i_mem[oy * src_w + ox]) begin
        $display("Mismatch at %0t: o_out_wdata[%0d] addr %0d actual 0x%02h expected 0x%02h",
                 $time, lane, addr, i_wdata[lane], i_mem[oy * src_w + ox]);
        count_error();
      end
    end
  endtask

  task automatic finish_frame();
    int missing;
    missing = 0;
    if (!active) begin
      $display("Error at %0t: o_done pulsed with no frame in progress", $time);
      count_error();
      return;
    end
    o_checks++;
    if (i_busy) begin
      $display("Error at %0t: o_busy is still high while o_done pulses", $time);
      count_error();
    end
    if (int'(i_out_w) != exp_w) begin
      $display("Mismatch at %0t: o_out_w actual %0d expected %0d", $time, i_out_w, exp_w);
      count_error();
    end
    if (int'(i_out_h) != exp_h) begin
      $display("Mismatch at %0t: o_out_h actual %0d expected %0d", $time, i_out_h, exp_h);
      count_error();
    end
    for (int a = 0; a < exp_w * exp_h; a++) begin
      if (hits[a] == 0) begin
        missing++;
      end
    end
    if (missing != 0) begin
      $display("Error at %0t: %0d output pixels were never written", $time, missing);
      count_error();
    end
    $display("Frame %0d: in %0dx%0d, scale 0x%04h, out %0dx%0d, %0d writes, %0d errors",
             o_frames, src_w, src_h, src_scale, exp_w, exp_h, frame_writes, frame_errors);
    o_frames++;
    active = 1'b0;
  endtask

  // Everything sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (!rst_n) begin
      active       = 1'b0;
      frame_errors = 0;
      o_frames     = 0;
      o_checks     = 0;
      o_errors     = 0;
    end else begin
      if (i_start && !i_busy) begin
        load_frame();
      end
      for (int l = 0; l < LANES; l++) begin
        if (i_we[l]) begin
          check_write(l);
        end
      end
      if (i_done) begin
        finish_frame();
      end
    end
  end

endmodule

/* verif/bilinear_props.sv */
`timescale 1ns/1ps

module bilinear_props (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           i_busy,
  input logic                           i_done,
  input logic [bilinear_pkg::LANES-1:0] i_we
);

  int fail_count = 0;

  // Write ports stay quiet outside a frame
  we_in_frame: assert property (@(posedge clk) disable iff (!rst_n) (|i_we) |-> i_busy)
    else begin
      fail_count++;
      $error("write enable raised while busy is low");
    end

  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) i_done |=> !i_done)
    else begin
      fail_count++;
      $error("done held high for more than one cycle");
    end

endmodule

bind bilinear_simd4 bilinear_props u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .i_busy (o_busy),
  .i_done (o_done),
  .i_we   (o_out_we)
);

/* verif/tb_bilinear_simd4.sv */
`timescale 1ns/1ps

module tb_bilinear_simd4;
  import bilinear_pkg::*;

  localparam int AW       = 19;
  localparam int FRAMES   = 8;
  localparam int MARGIN   = 200;
  localparam int MEM_SIZE = 256;

  logic                              clk;
  logic                              rst_n;
  logic                              start;
  logic                              busy;
  logic                              done;
  dim_t                              in_w;
  dim_t                              in_h;
  scale_t                            scale_q88;
  dim_t                              out_w;
  dim_t                              out_h;
  logic [LANES-1:0][NBR-1:0][AW-1:0] in_raddr;
  pixel_t [LANES-1:0][NBR-1:0]       in_rdata;
  logic [LANES-1:0][AW-1:0]          out_waddr;
  pixel_t [LANES-1:0]                out_wdata;
  logic [LANES-1:0]                  out_we;

  pixel_t mem         [0:MEM_SIZE-1];
  dim_t   frame_w     [0:FRAMES-1];
  dim_t   frame_h     [0:FRAMES-1];
  scale_t frame_scale [0:FRAMES-1];
  int     seed;
  int     cycles;
  int     cycle_limit;
  int     frames_done;
  int     checks;
  int     errors;

  bilinear_simd4 #(
    .AW (AW)
  ) u_bilinear_simd4 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (start),
    .o_busy      (busy),
    .o_done      (done),
    .i_in_w      (in_w),
    .i_in_h      (in_h),
    .i_scale_q88 (scale_q88),
    .o_out_w     (out_w),
    .o_out_h     (out_h),
    .o_in_raddr  (in_raddr),
    .i_in_rdata  (in_rdata),
    .o_out_waddr (out_waddr),
    .o_out_wdata (out_wdata),
    .o_out_we    (out_we)
  );

  bilinear_checker #(
    .AW (AW)
  ) u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (start),
    .i_in_w      (in_w),
    .i_in_h      (in_h),
    .i_scale_q88 (scale_q88),
    .i_busy      (busy),
    .i_done      (done),
    .i_out_w     (out_w),
    .i_out_h     (out_h),
    .i_waddr     (out_waddr),
    .i_wdata     (out_wdata),
    .i_we        (out_we),
    .i_mem       (mem),
    .o_frames    (frames_done),
    .o_checks    (checks),
    .o_errors    (errors)
  );

  always #20 clk = ~clk;

  // --------------------
  // Input memory model
  // --------------------
  // Combinational read of all sixteen neighbour ports
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      for (int n = 0; n < NBR; n++) begin
        if (in_raddr[l][n] < AW'(MEM_SIZE)) begin
          in_rdata[l][n] = mem[in_raddr[l][n][7:0]];
        end else begin
          in_rdata[l][n] = '0;
        end
      end
    end
  end

  // Cycle budget guard
  always @(posedge clk) begin
    if (!rst_n) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
        $display("Timeout: the DUT did not finish all frames within %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
      end
    end
  end

  function automatic int rand_below(int n);
    int r;
    r = $random(seed);
    return (r & 32'h7FFF_FFFF) % n;
  endfunction

  // --------------------
  // Frame list
  // --------------------
  task automatic plan_frames();
    int ow;
    int oh;
    // Unit scale with a partial last group goes first
    frame_w[0]     = 16'd7;
    frame_h[0]     = 16'd5;
    frame_scale[0] = 16'h0100;
    for (int f = 1; f < FRAMES; f++) begin
      frame_w[f]     = dim_t'(2 + rand_below(15));
      frame_h[f]     = dim_t'(2 + rand_below(15));
      frame_scale[f] = scale_t'(128 + rand_below(641));
    end
    cycle_limit = MARGIN;
    for (int f = 0; f < FRAMES; f++) begin
      ow = (int'(frame_w[f]) * int'(frame_scale[f])) >> 8;
      oh = (int'(frame_h[f]) * int'(frame_scale[f])) >> 8;
      // Six stages per group plus row and frame overhead
      cycle_limit += 7 * (((ow + LANES - 1) / LANES) * oh + oh + 4);
    end
  endtask

  task automatic run_frame(input dim_t w, input dim_t h, input scale_t s);
    @(posedge clk);
    in_w      <= w;
    in_h      <= h;
    scale_q88 <= s;
    start     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    in_w      = 16'd2;
    in_h      = 16'd2;
    scale_q88 = 16'h0100;
    seed      = 35780;
    for (int a = 0; a < MEM_SIZE; a++) begin
      mem[a] = pixel_t'($random(seed));
    end
    plan_frames();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int f = 0; f < FRAMES; f++) begin
      run_frame(frame_w[f], frame_h[f], frame_scale[f]);
    end
    repeat (3) @(posedge clk);
    $display("Summary: %0d of %0d frames, %0d checks, %0d errors, %0d assertion failures",
             frames_done, FRAMES, checks, errors, u_bilinear_simd4.u_props.fail_count);
    if (errors == 0 && frames_done == FRAMES && u_bilinear_simd4.u_props.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
